/* include/mem_stage_cfg.svh */
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// Data and address width.
`define XLEN 64

// Register file index width.
`define REG_INDEX_W 5

// Data RAM depth in 64-bit words.
`define RAM_WORDS 256

// Word index width, taken from address bits 10 down to 3.
`define RAM_INDEX_W 8

`endif

/* design/mem_stage_pkg.sv */
package mem_stage_pkg;

    // Load width and extension.
    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_H  = 3'd1,
        LD_W  = 3'd2,
        LD_D  = 3'd3,
        LD_BU = 3'd4,
        LD_HU = 3'd5,
        LD_WU = 3'd6
    } load_type_e;

    // Store width.
    typedef enum logic [1:0] {
        ST_B = 2'd0,
        ST_H = 2'd1,
        ST_W = 2'd2,
        ST_D = 2'd3
    } store_type_e;

    // APB transfer sequencer in the LSU.
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SETUP  = 2'd1,
        ACCESS = 2'd2
    } lsu_state_e;

    // Arbiter bus ownership.
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

endpackage

/* design/ex2mem.sv */
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module ex2mem (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        ex2mem_inst_valid_i,
    input  logic                        ex2mem_flush_i,
    input  logic                        ex2mem_hold_i,

    input  logic [`REG_INDEX_W-1:0]     ex2mem_rd_index_i,
    input  logic                        ex2mem_rd_en_i,
    input  logic                        ex2mem_mem_read_i,
    input  logic                        ex2mem_mem_write_i,
    input  mem_stage_pkg::load_type_e   ex2mem_load_type_i,
    input  mem_stage_pkg::store_type_e  ex2mem_store_type_i,
    input  logic [`XLEN-1:0]            ex2mem_rd_data_i,
    input  logic [`XLEN-1:0]            ex2mem_rs2_data_i,

    output logic                        ex2mem_inst_valid_o,
    output logic [`REG_INDEX_W-1:0]     ex2mem_rd_index_o,
    output logic                        ex2mem_rd_en_o,
    output logic                        ex2mem_mem_read_o,
    output logic                        ex2mem_mem_write_o,
    output mem_stage_pkg::load_type_e   ex2mem_load_type_o,
    output mem_stage_pkg::store_type_e  ex2mem_store_type_o,
    output logic [`XLEN-1:0]            ex2mem_rd_data_o,
    output logic [`XLEN-1:0]            ex2mem_rs2_data_o
);

    logic accept;
    logic bubble;

    assign accept = ex2mem_inst_valid_i & ~ex2mem_hold_i;
    assign bubble = accept & ex2mem_flush_i;

    // Valid marks a slot that was just latched or is still held.
    always_ff @(posedge clk) begin
        if (rst) begin
            ex2mem_inst_valid_o <= 1'b0;
            ex2mem_rd_en_o      <= 1'b0;
            ex2mem_mem_read_o   <= 1'b0;
            ex2mem_mem_write_o  <= 1'b0;
        end
        else if (accept) begin
            ex2mem_inst_valid_o <= ~ex2mem_flush_i;
            ex2mem_rd_en_o      <= ex2mem_rd_en_i & ~ex2mem_flush_i;
            ex2mem_mem_read_o   <= ex2mem_mem_read_i & ~ex2mem_flush_i;
            ex2mem_mem_write_o  <= ex2mem_mem_write_i & ~ex2mem_flush_i;
        end
        else if (!ex2mem_hold_i) begin
            ex2mem_inst_valid_o <= 1'b0;
        end
    end

    // Payload zeroed for a bubble.
    always_ff @(posedge clk) begin
        if (bubble) begin
            ex2mem_rd_index_o   <= '0;
            ex2mem_load_type_o  <= mem_stage_pkg::LD_B;
            ex2mem_store_type_o <= mem_stage_pkg::ST_B;
            ex2mem_rd_data_o    <= '0;
            ex2mem_rs2_data_o   <= '0;
        end
        else if (accept) begin
            ex2mem_rd_index_o   <= ex2mem_rd_index_i;
            ex2mem_load_type_o  <= ex2mem_load_type_i;
            ex2mem_store_type_o <= ex2mem_store_type_i;
            ex2mem_rd_data_o    <= ex2mem_rd_data_i;
            ex2mem_rs2_data_o   <= ex2mem_rs2_data_i;
        end
    end

    // Upstream decode never issues both.
    assert property (@(posedge clk) disable iff (rst)
        !(ex2mem_mem_read_o && ex2mem_mem_write_o));

endmodule

/* design/lsu.sv */
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module lsu (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        inst_valid_i,
    input  logic [`REG_INDEX_W-1:0]     rd_index_i,
    input  logic                        rd_en_i,
    input  logic                        mem_read_i,
    input  logic                        mem_write_i,
    input  mem_stage_pkg::load_type_e   load_type_i,
    input  mem_stage_pkg::store_type_e  store_type_i,
    input  logic [`XLEN-1:0]            rd_data_i,
    input  logic [`XLEN-1:0]            rs2_data_i,

    output logic                        hold_o,
    output logic                        stall_o,

    output logic                        m_psel_o,
    output logic                        m_penable_o,
    output logic                        m_pwrite_o,
    output logic [`XLEN-1:0]            m_paddr_o,
    output logic [`XLEN-1:0]            m_pwdata_o,
    output logic [`XLEN/8-1:0]          m_pstrb_o,
    input  logic [`XLEN-1:0]            m_prdata_i,
    input  logic                        m_pready_i,

    output logic                        wb_valid_o,
    output logic [`REG_INDEX_W-1:0]     wb_rd_index_o,
    output logic [`XLEN-1:0]            wb_rd_data_o
);

    mem_stage_pkg::lsu_state_e state_r;

    logic                   done_r;
    logic                   mem_op;
    logic                   req;
    logic                   xfer_end;
    logic [2:0]             offset;
    logic [2:0]             st_mask;
    logic [2:0]             ld_mask;
    logic                   misaligned;
    logic [`XLEN/8-1:0]     strb;
    logic [`XLEN-1:0]       load_shifted;
    logic [`XLEN-1:0]       load_data;

    assign mem_op   = mem_read_i | mem_write_i;
    assign offset   = rd_data_i[2:0];
    assign xfer_end = (state_r == mem_stage_pkg::ACCESS) & m_pready_i;

    // Done covers the cycle after pready, until ex2mem moves on.
    assign req     = inst_valid_i & mem_op & ~done_r;
    assign stall_o = req;
    assign hold_o  = req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_r <= mem_stage_pkg::IDLE;
            done_r  <= 1'b0;
        end
        else begin
            done_r <= xfer_end;
            case (state_r)
                mem_stage_pkg::IDLE: begin
                    if (req) begin
                        state_r <= mem_stage_pkg::SETUP;
                    end
                end
                mem_stage_pkg::SETUP: begin
                    state_r <= mem_stage_pkg::ACCESS;
                end
                mem_stage_pkg::ACCESS: begin
                    if (m_pready_i) begin
                        state_r <= mem_stage_pkg::IDLE;
                    end
                end
                default: begin
                    state_r <= mem_stage_pkg::IDLE;
                end
            endcase
        end
    end

    assign m_psel_o    = state_r != mem_stage_pkg::IDLE;
    assign m_penable_o = state_r == mem_stage_pkg::ACCESS;
    assign m_pwrite_o  = mem_write_i;
    assign m_paddr_o   = rd_data_i;
    assign m_pstrb_o   = mem_write_i ? strb : '0;

    // Store data replicated into every lane.
    always_comb begin
        case (store_type_i)
            mem_stage_pkg::ST_B: begin
                m_pwdata_o = {8{rs2_data_i[7:0]}};
                strb       = 8'b0000_0001 << offset;
                st_mask    = 3'b000;
            end
            mem_stage_pkg::ST_H: begin
                m_pwdata_o = {4{rs2_data_i[15:0]}};
                strb       = 8'b0000_0011 << offset;
                st_mask    = 3'b001;
            end
            mem_stage_pkg::ST_W: begin
                m_pwdata_o = {2{rs2_data_i[31:0]}};
                strb       = 8'b0000_1111 << offset;
                st_mask    = 3'b011;
            end
            default: begin
                m_pwdata_o = rs2_data_i;
                strb       = 8'b1111_1111;
                st_mask    = 3'b111;
            end
        endcase
    end

    assign load_shifted = m_prdata_i >> {offset, 3'b000};

    always_comb begin
        load_data = load_shifted;
        ld_mask   = 3'b111;
        case (load_type_i)
            mem_stage_pkg::LD_B: begin
                load_data = {{(`XLEN-8){load_shifted[7]}}, load_shifted[7:0]};
                ld_mask   = 3'b000;
            end
            mem_stage_pkg::LD_BU: begin
                load_data = {{(`XLEN-8){1'b0}}, load_shifted[7:0]};
                ld_mask   = 3'b000;
            end
            mem_stage_pkg::LD_H: begin
                load_data = {{(`XLEN-16){load_shifted[15]}}, load_shifted[15:0]};
                ld_mask   = 3'b001;
            end
            mem_stage_pkg::LD_HU: begin
                load_data = {{(`XLEN-16){1'b0}}, load_shifted[15:0]};
                ld_mask   = 3'b001;
            end
            mem_stage_pkg::LD_W: begin
                load_data = {{(`XLEN-32){load_shifted[31]}}, load_shifted[31:0]};
                ld_mask   = 3'b011;
            end
            mem_stage_pkg::LD_WU: begin
                load_data = {{(`XLEN-32){1'b0}}, load_shifted[31:0]};
                ld_mask   = 3'b011;
            end
            default: begin
                load_data = load_shifted;
            end
        endcase
    end

    assign misaligned = |(offset & (mem_read_i ? ld_mask : st_mask));

    // ALU results the cycle after latching, loads the edge after pready.
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end
        else begin
            wb_valid_o <= rd_en_i & ((inst_valid_i & ~mem_op) | (xfer_end & mem_read_i));
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_index_o <= rd_index_i;
        wb_rd_data_o  <= mem_read_i ? load_data : rd_data_i;
    end

    assert property (@(posedge clk) disable iff (rst) req |-> !misaligned);

    // Relies on ex2mem holding its slot while stalled.
    assert property (@(posedge clk) disable iff (rst)
        (state_r == mem_stage_pkg::ACCESS) |->
            $stable(m_paddr_o) && $stable(m_pwdata_o) &&
            $stable(m_pstrb_o) && $stable(m_pwrite_o));

endmodule

/* design/apb_arbiter.sv */
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module apb_arbiter (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    s0_psel_i,
    input  logic                    s0_penable_i,
    input  logic                    s0_pwrite_i,
    input  logic [`XLEN-1:0]        s0_paddr_i,
    input  logic [`XLEN-1:0]        s0_pwdata_i,
    input  logic [`XLEN/8-1:0]      s0_pstrb_i,
    output logic [`XLEN-1:0]        s0_prdata_o,
    output logic                    s0_pready_o,

    input  logic                    s1_psel_i,
    input  logic                    s1_penable_i,
    input  logic                    s1_pwrite_i,
    input  logic [`XLEN-1:0]        s1_paddr_i,
    input  logic [`XLEN-1:0]        s1_pwdata_i,
    input  logic [`XLEN/8-1:0]      s1_pstrb_i,
    output logic [`XLEN-1:0]        s1_prdata_o,
    output logic                    s1_pready_o,

    output logic                    m_psel_o,
    output logic                    m_penable_o,
    output logic                    m_pwrite_o,
    output logic [`XLEN-1:0]        m_paddr_o,
    output logic [`XLEN-1:0]        m_pwdata_o,
    output logic [`XLEN/8-1:0]      m_pstrb_o,
    input  logic [`XLEN-1:0]        m_prdata_i,
    input  logic                    m_pready_i
);

    mem_stage_pkg::arb_state_e state_r;

    logic busy;
    logic grant_r;
    logic last_r;
    logic pick;
    logic sel;

    assign busy = state_r == mem_stage_pkg::ARB_BUSY;

    // Round robin on contention, else whichever port asks.
    assign pick = (s0_psel_i & s1_psel_i) ? ~last_r : s1_psel_i;
    assign sel  = busy ? grant_r : pick;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_r <= mem_stage_pkg::ARB_IDLE;
            grant_r <= 1'b0;
            last_r  <= 1'b1;
        end
        else if (!busy) begin
            if (s0_psel_i | s1_psel_i) begin
                state_r <= mem_stage_pkg::ARB_BUSY;
                grant_r <= pick;
                last_r  <= pick;
            end
        end
        else if (m_pready_i) begin
            state_r <= mem_stage_pkg::ARB_IDLE;
        end
    end

    // The idle cycle doubles as the RAM setup phase.
    assign m_psel_o    = busy | s0_psel_i | s1_psel_i;
    assign m_penable_o = busy & (grant_r ? s1_penable_i : s0_penable_i);
    assign m_pwrite_o  = sel ? s1_pwrite_i : s0_pwrite_i;
    assign m_paddr_o   = sel ? s1_paddr_i : s0_paddr_i;
    assign m_pwdata_o  = sel ? s1_pwdata_i : s0_pwdata_i;
    assign m_pstrb_o   = sel ? s1_pstrb_i : s0_pstrb_i;

    assign s0_prdata_o = m_prdata_i;
    assign s1_prdata_o = m_prdata_i;
    assign s0_pready_o = busy & ~grant_r & m_pready_i;
    assign s1_pready_o = busy & grant_r & m_pready_i;

    // A RAM completion reaches exactly one requesting port.
    assert property (@(posedge clk) disable iff (rst)
        (m_pready_i && m_penable_o) |->
            $onehot({s0_pready_o & s0_psel_i, s1_pready_o & s1_psel_i}));

endmodule

/* design/data_ram.sv */
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module data_ram (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [`XLEN-1:0]        paddr_i,
    input  logic [`XLEN-1:0]        pwdata_i,
    input  logic [`XLEN/8-1:0]      pstrb_i,
    output logic [`XLEN-1:0]        prdata_o,
    output logic                    pready_o
);

    logic [`XLEN-1:0]           mem [`RAM_WORDS];
    logic [`RAM_INDEX_W-1:0]    index;
    logic                       setup;
    logic                       access;

    // Upper address bits ignored.
    assign index  = paddr_i[`RAM_INDEX_W+2:3];
    assign setup  = psel_i & ~penable_i;
    assign access = psel_i & penable_i;

    // Ready in the first access cycle, so no wait states.
    always_ff @(posedge clk) begin
        if (rst) begin
            pready_o <= 1'b0;
        end
        else begin
            pready_o <= setup;
        end
    end

    // Read word fetched during setup.
    always_ff @(posedge clk) begin
        if (setup && !pwrite_i) begin
            prdata_o <= mem[index];
        end
    end

    always_ff @(posedge clk) begin
        if (access && pwrite_i) begin
            for (int b = 0; b < `XLEN/8; b++) begin
                if (pstrb_i[b]) begin
                    mem[index][8*b +: 8] <= pwdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

/* design/mem_stage_top.sv */
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module mem_stage_top (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        ex_valid_i,
    input  logic                        ex_flush_i,
    input  logic [`REG_INDEX_W-1:0]     ex_rd_index_i,
    input  logic                        ex_rd_en_i,
    input  logic                        ex_mem_read_i,
    input  logic                        ex_mem_write_i,
    input  mem_stage_pkg::load_type_e   ex_load_type_i,
    input  mem_stage_pkg::store_type_e  ex_store_type_i,
    input  logic [`XLEN-1:0]            ex_rd_data_i,
    input  logic [`XLEN-1:0]            ex_rs2_data_i,

    output logic                        stall_o,
    output logic                        wb_valid_o,
    output logic [`REG_INDEX_W-1:0]     wb_rd_index_o,
    output logic [`XLEN-1:0]            wb_rd_data_o,

    input  logic                        host_psel_i,
    input  logic                        host_penable_i,
    input  logic                        host_pwrite_i,
    input  logic [`XLEN-1:0]            host_paddr_i,
    input  logic [`XLEN-1:0]            host_pwdata_i,
    input  logic [`XLEN/8-1:0]          host_pstrb_i,
    output logic [`XLEN-1:0]            host_prdata_o,
    output logic                        host_pready_o
);

    logic                           hold;
    logic                           mem_valid;
    logic [`REG_INDEX_W-1:0]        mem_rd_index;
    logic                           mem_rd_en;
    logic                           mem_read;
    logic                           mem_write;
    mem_stage_pkg::load_type_e      mem_load_type;
    mem_stage_pkg::store_type_e     mem_store_type;
    logic [`XLEN-1:0]               mem_rd_data;
    logic [`XLEN-1:0]               mem_rs2_data;

    logic                           lsu_psel;
    logic                           lsu_penable;
    logic                           lsu_pwrite;
    logic [`XLEN-1:0]               lsu_paddr;
    logic [`XLEN-1:0]               lsu_pwdata;
    logic [`XLEN/8-1:0]             lsu_pstrb;
    logic [`XLEN-1:0]               lsu_prdata;
    logic                           lsu_pready;

    logic                           ram_psel;
    logic                           ram_penable;
    logic                           ram_pwrite;
    logic [`XLEN-1:0]               ram_paddr;
    logic [`XLEN-1:0]               ram_pwdata;
    logic [`XLEN/8-1:0]             ram_pstrb;
    logic [`XLEN-1:0]               ram_prdata;
    logic                           ram_pready;

    ex2mem u_ex2mem (
        .clk                 (clk),                 .rst                 (rst),
        .ex2mem_inst_valid_i (ex_valid_i),          .ex2mem_flush_i      (ex_flush_i),
        .ex2mem_hold_i       (hold),
        .ex2mem_rd_index_i   (ex_rd_index_i),       .ex2mem_rd_en_i      (ex_rd_en_i),
        .ex2mem_mem_read_i   (ex_mem_read_i),       .ex2mem_mem_write_i  (ex_mem_write_i),
        .ex2mem_load_type_i  (ex_load_type_i),      .ex2mem_store_type_i (ex_store_type_i),
        .ex2mem_rd_data_i    (ex_rd_data_i),        .ex2mem_rs2_data_i   (ex_rs2_data_i),
        .ex2mem_inst_valid_o (mem_valid),
        .ex2mem_rd_index_o   (mem_rd_index),        .ex2mem_rd_en_o      (mem_rd_en),
        .ex2mem_mem_read_o   (mem_read),            .ex2mem_mem_write_o  (mem_write),
        .ex2mem_load_type_o  (mem_load_type),       .ex2mem_store_type_o (mem_store_type),
        .ex2mem_rd_data_o    (mem_rd_data),         .ex2mem_rs2_data_o   (mem_rs2_data)
    );

    lsu u_lsu (
        .clk          (clk),             .rst           (rst),
        .inst_valid_i (mem_valid),       .rd_index_i    (mem_rd_index),
        .rd_en_i      (mem_rd_en),       .mem_read_i    (mem_read),
        .mem_write_i  (mem_write),       .load_type_i   (mem_load_type),
        .store_type_i (mem_store_type),  .rd_data_i     (mem_rd_data),
        .rs2_data_i   (mem_rs2_data),
        .hold_o       (hold),            .stall_o       (stall_o),
        .m_psel_o     (lsu_psel),        .m_penable_o   (lsu_penable),
        .m_pwrite_o   (lsu_pwrite),      .m_paddr_o     (lsu_paddr),
        .m_pwdata_o   (lsu_pwdata),      .m_pstrb_o     (lsu_pstrb),
        .m_prdata_i   (lsu_prdata),      .m_pready_i    (lsu_pready),
        .wb_valid_o   (wb_valid_o),      .wb_rd_index_o (wb_rd_index_o),
        .wb_rd_data_o (wb_rd_data_o)
    );

    apb_arbiter u_apb_arbiter (
        .clk          (clk),             .rst          (rst),
        .s0_psel_i    (lsu_psel),        .s0_penable_i (lsu_penable),
        .s0_pwrite_i  (lsu_pwrite),      .s0_paddr_i   (lsu_paddr),
        .s0_pwdata_i  (lsu_pwdata),      .s0_pstrb_i   (lsu_pstrb),
        .s0_prdata_o  (lsu_prdata),      .s0_pready_o  (lsu_pready),
        .s1_psel_i    (host_psel_i),     .s1_penable_i (host_penable_i),
        .s1_pwrite_i  (host_pwrite_i),   .s1_paddr_i   (host_paddr_i),
        .s1_pwdata_i  (host_pwdata_i),   .s1_pstrb_i   (host_pstrb_i),
        .s1_prdata_o  (host_prdata_o),   .s1_pready_o  (host_pready_o),
        .m_psel_o     (ram_psel),        .m_penable_o  (ram_penable),
        .m_pwrite_o   (ram_pwrite),      .m_paddr_o    (ram_paddr),
        .m_pwdata_o   (ram_pwdata),      .m_pstrb_o    (ram_pstrb),
        .m_prdata_i   (ram_prdata),      .m_pready_i   (ram_pready)
    );

    data_ram u_data_ram (
        .clk       (clk),          .rst       (rst),
        .psel_i    (ram_psel),     .penable_i (ram_penable),
        .pwrite_i  (ram_pwrite),   .paddr_i   (ram_paddr),
        .pwdata_i  (ram_pwdata),   .pstrb_i   (ram_pstrb),
        .prdata_o  (ram_prdata),   .pready_o  (ram_pready)
    );

endmodule

/* sim/tb_mem_stage.sv */
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module tb_mem_stage;

    // Operation counts per phase, used for the watchdog budget.
    localparam int N_INIT = 256;
    localparam int N_ALU = 40;
    localparam int N_STORE = 30;
    localparam int N_LOAD = 40;
    localparam int N_FLUSH = 20;
    localparam int N_MIX = 60;
    localparam int N_HOST = 30;
    localparam int TOTAL_OPS = N_INIT + N_ALU + N_STORE + N_LOAD + N_FLUSH + N_MIX + N_HOST;

    logic clk;
    logic rst;
    logic ex_valid_i;
    logic ex_flush_i;
    logic [`REG_INDEX_W-1:0] ex_rd_index_i;
    logic ex_rd_en_i;
    logic ex_mem_read_i;
    logic ex_mem_write_i;
    mem_stage_pkg::load_type_e ex_load_type_i;
    mem_stage_pkg::store_type_e ex_store_type_i;
    logic [`XLEN-1:0] ex_rd_data_i;
    logic [`XLEN-1:0] ex_rs2_data_i;
    logic stall_o;
    logic wb_valid_o;
    logic [`REG_INDEX_W-1:0] wb_rd_index_o;
    logic [`XLEN-1:0] wb_rd_data_o;
    logic host_psel_i;
    logic host_penable_i;
    logic host_pwrite_i;
    logic [`XLEN-1:0] host_paddr_i;
    logic [`XLEN-1:0] host_pwdata_i;
    logic [`XLEN/8-1:0] host_pstrb_i;
    logic [`XLEN-1:0] host_prdata_o;
    logic host_pready_o;

    integer seed;
    longint cyc;
    int accepted_wb;
    int seen_wb;
    logic [`XLEN-1:0] model [256];

    // Expected write-backs in order; due of -1 means any cycle.
    logic [`REG_INDEX_W-1:0] exp_idx [$];
    logic [`XLEN-1:0] exp_data [$];
    longint exp_due [$];
    logic exp_load [$];
    mem_stage_pkg::load_type_e exp_type [$];

    mem_stage_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        #(64'(TOTAL_OPS) * 20 * 100);
        $display("Timeout: the test did not finish within its cycle budget.");
        $display(">>> FAIL");
        $fatal(1, "Simulation timed out.");
    end

    task automatic stop_on_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "Check failed.");
    endtask

    task automatic check_wb(input logic [`REG_INDEX_W-1:0] idx, input logic [`XLEN-1:0] val);
        if (wb_rd_index_o !== idx || wb_rd_data_o !== val) begin
            stop_on_error($sformatf("write-back rd=%0d data=%h, expected rd=%0d data=%h",
                wb_rd_index_o, wb_rd_data_o, idx, val));
        end
    endtask

    task automatic check_host_read(input logic [`XLEN-1:0] val);
        if (host_prdata_o !== val) begin
            stop_on_error($sformatf("host read %h, expected %h", host_prdata_o, val));
        end
    endtask

    task automatic check_load_ext(input mem_stage_pkg::load_type_e lt,
                                  input logic [`XLEN-1:0] val);
        if (wb_rd_data_o !== val) begin
            stop_on_error($sformatf("load %s returned %h, expected %h",
                lt.name(), wb_rd_data_o, val));
        end
    endtask

    function automatic int load_size(input mem_stage_pkg::load_type_e lt);
        case (lt)
            mem_stage_pkg::LD_B, mem_stage_pkg::LD_BU: return 1;
            mem_stage_pkg::LD_H, mem_stage_pkg::LD_HU: return 2;
            mem_stage_pkg::LD_W, mem_stage_pkg::LD_WU: return 4;
            default: return 8;
        endcase
    endfunction

    // Reference extension from the memory bytes at the access offset.
    function automatic logic [`XLEN-1:0] load_expect(input mem_stage_pkg::load_type_e lt,
                                                     input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] w;
        w = model[addr[10:3]] >> (8 * addr[2:0]);
        case (lt)
            mem_stage_pkg::LD_B: return 64'(signed'(w[7:0]));
            mem_stage_pkg::LD_BU: return 64'(w[7:0]);
            mem_stage_pkg::LD_H: return 64'(signed'(w[15:0]));
            mem_stage_pkg::LD_HU: return 64'(w[15:0]);
            mem_stage_pkg::LD_W: return 64'(signed'(w[31:0]));
            mem_stage_pkg::LD_WU: return 64'(w[31:0]);
            default: return w;
        endcase
    endfunction

    // Drives one instruction and returns once it will be accepted on the next edge.
    task automatic issue(input logic flush, input logic [`REG_INDEX_W-1:0] rd,
                         input logic rd_en, input logic mr, input logic mw,
                         input mem_stage_pkg::load_type_e lt,
                         input mem_stage_pkg::store_type_e st,
                         input logic [`XLEN-1:0] rd_data, input logic [`XLEN-1:0] rs2);
        int sz;
        @(posedge clk);
        ex_valid_i <= 1'b1;
        ex_flush_i <= flush;
        ex_rd_index_i <= rd;
        ex_rd_en_i <= rd_en;
        ex_mem_read_i <= mr;
        ex_mem_write_i <= mw;
        ex_load_type_i <= lt;
        ex_store_type_i <= st;
        ex_rd_data_i <= rd_data;
        ex_rs2_data_i <= rs2;
        do begin
            @(negedge clk);
        end while (stall_o);
        if (!flush) begin
            if (mw) begin
                sz = 1 << st;
                for (int b = 0; b < sz; b++) begin
                    model[rd_data[10:3]][8*(rd_data[2:0]+b) +: 8] = rs2[8*b +: 8];
                end
            end
            else if (rd_en) begin
                exp_idx.push_back(rd);
                exp_data.push_back(mr ? load_expect(lt, rd_data) : rd_data);
                exp_due.push_back(mr ? -1 : cyc + 2);
                exp_load.push_back(mr);
                exp_type.push_back(lt);
                accepted_wb++;
            end
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        ex_valid_i <= 1'b0;
        ex_flush_i <= 1'b0;
    endtask

    // Kind 0 is an ALU op, 1 a store, 2 a load; the address stays in the low half.
    task automatic random_op(input int kind, input logic flush, output logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] data;
        mem_stage_pkg::load_type_e lt;
        mem_stage_pkg::store_type_e st;
        int sz;
        lt = mem_stage_pkg::load_type_e'(($random(seed) & 32'h7fff_ffff) % 7);
        st = mem_stage_pkg::store_type_e'($random(seed) & 3);
        sz = (kind == 1) ? (1 << st) : load_size(lt);
        addr = {$random(seed), $random(seed)};
        addr[10:3] = $random(seed) & 8'h7f;
        addr[2:0] = ($random(seed) & 7) & ~(sz - 1);
        data = {$random(seed), $random(seed)};
        case (kind)
            0: issue(flush, $random(seed), $random(seed), 1'b0, 1'b0, lt, st, data, addr);
            1: issue(flush, $random(seed), 1'b0, 1'b0, 1'b1, lt, st, addr, data);
            default: issue(flush, $random(seed), 1'b1, 1'b1, 1'b0, lt, st, addr, data);
        endcase
    endtask

    task automatic host_xfer(input logic wr, input logic [`XLEN-1:0] addr,
                             input logic [`XLEN-1:0] data, input logic [7:0] strb);
        @(posedge clk);
        host_psel_i <= 1'b1;
        host_penable_i <= 1'b0;
        host_pwrite_i <= wr;
        host_paddr_i <= addr;
        host_pwdata_i <= data;
        host_pstrb_i <= wr ? strb : 8'h00;
        @(posedge clk);
        host_penable_i <= 1'b1;
        do begin
            @(negedge clk);
        end while (!host_pready_o);
        if (wr) begin
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) begin
                    model[addr[10:3]][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        else begin
            check_host_read(model[addr[10:3]]);
        end
        @(posedge clk);
        host_psel_i <= 1'b0;
        host_penable_i <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (!rst && wb_valid_o) begin
            if (exp_idx.size() == 0) begin
                stop_on_error("write-back seen with none expected");
            end
            if (exp_due[0] >= 0 && exp_due[0] != cyc) begin
                stop_on_error($sformatf("ALU write-back at cycle %0d, expected cycle %0d",
                    cyc, exp_due[0]));
            end
            if (exp_load[0]) begin
                check_load_ext(exp_type[0], exp_data[0]);
            end
            check_wb(exp_idx[0], exp_data[0]);
            void'(exp_idx.pop_front());
            void'(exp_data.pop_front());
            void'(exp_due.pop_front());
            void'(exp_load.pop_front());
            void'(exp_type.pop_front());
            seen_wb++;
        end
    end

    initial begin
        logic [`XLEN-1:0] addr;
        seed = 32'h7828;
        cyc = 0;
        accepted_wb = 0;
        seen_wb = 0;
        rst = 1'b1;
        ex_valid_i = 1'b0;
        ex_flush_i = 1'b0;
        ex_rd_index_i = '0;
        ex_rd_en_i = 1'b0;
        ex_mem_read_i = 1'b0;
        ex_mem_write_i = 1'b0;
        ex_load_type_i = mem_stage_pkg::LD_B;
        ex_store_type_i = mem_stage_pkg::ST_B;
        ex_rd_data_i = '0;
        ex_rs2_data_i = '0;
        host_psel_i = 1'b0;
        host_penable_i = 1'b0;
        host_pwrite_i = 1'b0;
        host_paddr_i = '0;
        host_pwdata_i = '0;
        host_pstrb_i = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Quiet after reset.
        repeat (20) begin
            @(negedge clk);
            if (stall_o || wb_valid_o || host_pready_o) begin
                $display("Outputs became active after reset without any input activity.");
                $display(">>> FAIL");
                $fatal(1, "Idle check failed.");
            end
        end

        // Every word gets a value derived from its full index.
        for (int i = 0; i < N_INIT; i++) begin
            host_xfer(1'b1, 64'(i) << 3,
                {32'(i) * 32'h9e37_79b9 ^ 32'h7828, ~(32'(i) * 32'h85eb_ca6b)}, 8'hff);
        end

        for (int i = 0; i < N_ALU; i++) begin
            random_op(0, 1'b0, addr);
        end
        for (int i = 0; i < N_STORE; i++) begin
            random_op(1, 1'b0, addr);
        end
        for (int i = 0; i < N_LOAD; i++) begin
            random_op(2, 1'b0, addr);
        end

        // Flushed stores must leave memory untouched.
        for (int i = 0; i < N_FLUSH / 2; i++) begin
            random_op(0, 1'b1, addr);
            random_op(1, 1'b1, addr);
            issue(1'b0, 5'd7, 1'b1, 1'b1, 1'b0, mem_stage_pkg::LD_D, mem_stage_pkg::ST_B,
                {addr[63:3], 3'b000}, '0);
        end

        fork
            begin
                for (int i = 0; i < N_MIX; i++) begin
                    random_op(($random(seed) & 32'h7fff_ffff) % 3, 1'b0, addr);
                end
                go_idle();
            end
            begin
                for (int i = 0; i < N_HOST; i++) begin
                    host_xfer($random(seed) & 1, {$random(seed), $random(seed)} | 64'h400,
                        {$random(seed), $random(seed)}, $random(seed));
                end
            end
        join

        // A load retires on the edge where stall_o falls, an ALU op one edge after acceptance.
        do begin
            @(negedge clk);
        end while (stall_o);
        repeat (2) @(negedge clk);
        if (seen_wb != accepted_wb) begin
            $display("Write-back count %0d does not match accepted count %0d.",
                seen_wb, accepted_wb);
            $display(">>> FAIL");
            $fatal(1, "Write-back count mismatch.");
        end
        else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+include
design/mem_stage_pkg.sv
design/ex2mem.sv
design/lsu.sv
design/apb_arbiter.sv
design/data_ram.sv
design/mem_stage_top.sv
sim/tb_mem_stage.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module tb_mem_stage -Mdir obj_dir
	./obj_dir/Vtb_mem_stage

clean:
	rm -rf obj_dir
